// File: compile.f
+incdir+source
source/mem_stage_pkg.sv
source/mem_access_decode.sv
source/data_mem.sv
source/load_align.sv
source/mem_stage.sv
verif/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs mem_stage_tb with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f compile.f --top-module mem_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmem_stage_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0

// File: source/data_mem.sv
//##############################
// single cycle data memory, read is combinational
// address bits above the array are ignored
//##############################
`timescale 1ns/1ns
`default_nettype none
`include "mem_stage_defines.svh"

module data_mem
    import mem_stage_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             i_wr_en,
    input  wire logic             i_rd_en,
    input  wire byte_en_t         i_byte_en,
    input  wire logic [`XLEN-1:0] i_addr,
    input  wire logic [`XLEN-1:0] i_wdata,
    output word_bytes_t           o_rdata
);
    word_bytes_t mem [`DMEM_WORDS];

    // word index from the byte address
    logic [`DMEM_AW-1:0] word_idx;

    assign word_idx = i_addr[`DMEM_AW+1:2];

    // reset clears the whole array
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int w = 0; w < `DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (i_wr_en) begin
            // per lane write
            for (int b = 0; b < 4; b++) begin
                if (i_byte_en[b]) begin
                    mem[word_idx][b] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    // zero when no load is in stage 6
    assign o_rdata = i_rd_en ? mem[word_idx] : '0;

    // writes must land inside the array
    assert property (@(posedge clk) disable iff (!nrst)
        i_wr_en |-> (i_addr[`XLEN-1:`DMEM_AW+2] == '0));

endmodule

`default_nettype wire

// File: source/load_align.sv
//##############################
// assumes aligned offsets only
// halfwords at offset 0 or 2
//##############################
`timescale 1ns/1ns
`default_nettype none
`include "mem_stage_defines.svh"

module load_align
    import mem_stage_pkg::*;
(
    input  wire mem_op_e     i_load_op,
    input  wire logic [1:0]  i_byte_off,
    input  wire word_bytes_t i_rdata,
    output logic [`XLEN-1:0] o_mem_out
);
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // addressed byte
    assign sel_byte = i_rdata[i_byte_off];

    // upper or lower halfword
    assign sel_half = i_byte_off[1] ? {i_rdata[3], i_rdata[2]} : {i_rdata[1], i_rdata[0]};

    always_comb begin
        unique case (i_load_op)
            // sign extended
            MEM_LB:  o_mem_out = {{(`XLEN-8){sel_byte[7]}}, sel_byte};
            MEM_LH:  o_mem_out = {{(`XLEN-16){sel_half[15]}}, sel_half};
            // zero extended
            MEM_LBU: o_mem_out = {{(`XLEN-8){1'b0}}, sel_byte};
            MEM_LHU: o_mem_out = {{(`XLEN-16){1'b0}}, sel_half};
            // full word as read
            MEM_LW:  o_mem_out = i_rdata;
            // none, stores, dropped loads
            default: o_mem_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/mem_access_decode.sv
//##############################
// two register stages, no stall or flush
// store data must already sit in its byte lane
//##############################
`timescale 1ns/1ns
`default_nettype none
`include "mem_stage_defines.svh"

module mem_access_decode
    import mem_stage_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire mem_op_e          i_mem_op,
    input  wire logic [`XLEN-1:0] i_op_a,
    input  wire logic [`XLEN-1:0] i_op_b,
    input  wire logic [`XLEN-1:0] i_s_imm,
    output logic                  o_wr_en,
    output logic                  o_rd_en,
    output byte_en_t              o_byte_en,
    output logic [`XLEN-1:0]      o_addr,
    output logic [`XLEN-1:0]      o_wdata,
    output mem_op_e               o_load_op,
    output logic [1:0]            o_byte_off,
    output logic                  o_addr_misaligned
);
    // stage 5 registers
    mem_op_e          mem_op_q5;
    logic [`XLEN-1:0] op_a_q5;
    logic [`XLEN-1:0] op_b_q5;
    logic [`XLEN-1:0] s_imm_q5;

    // stage 5 decode
    logic [`XLEN-1:0] addr5;
    logic             is_half;
    logic             is_word;
    logic             is_load;
    logic             is_store;
    logic             misaligned5;
    byte_en_t         byte_en5;

    // stage 5 op code
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mem_op_q5 <= MEM_NONE;
        end else begin
            mem_op_q5 <= i_mem_op;
        end
    end

    always_ff @(posedge clk) begin
        op_a_q5  <= i_op_a;
        op_b_q5  <= i_op_b;
        s_imm_q5 <= i_s_imm;
    end

    // stores add the S offset, loads add op_b
    assign addr5 = mem_op_q5[3] ? (op_a_q5 + s_imm_q5) : (op_a_q5 + op_b_q5);

    assign is_half  = (mem_op_q5 == MEM_LH) || (mem_op_q5 == MEM_LHU) || (mem_op_q5 == MEM_SH);
    assign is_word  = (mem_op_q5 == MEM_LW) || (mem_op_q5 == MEM_SW);
    assign is_store = (mem_op_q5 == MEM_SB) || (mem_op_q5 == MEM_SH) || (mem_op_q5 == MEM_SW);
    assign is_load  = (mem_op_q5 == MEM_LB) || (mem_op_q5 == MEM_LH) || (mem_op_q5 == MEM_LW) ||
                      (mem_op_q5 == MEM_LBU) || (mem_op_q5 == MEM_LHU);

    // halfword needs bit 0 clear, word needs both low bits clear
    assign misaligned5 = (is_half && addr5[0]) || (is_word && (addr5[1:0] != 2'b00));

    // lane select from the low address bits
    always_comb begin
        byte_en5 = '0;
        if (!misaligned5) begin
            unique case (mem_op_q5)
                MEM_SB:  byte_en5 = byte_en_t'(4'b0001 << addr5[1:0]);
                MEM_SH:  byte_en5 = addr5[1] ? 4'b1100 : 4'b0011;
                MEM_SW:  byte_en5 = 4'b1111;
                default: byte_en5 = '0;
            endcase
        end
    end

    // stage 6 control
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            o_wr_en           <= 1'b0;
            o_rd_en           <= 1'b0;
            o_byte_en         <= '0;
            o_load_op         <= MEM_NONE;
            o_addr_misaligned <= 1'b0;
        end else begin
            o_wr_en           <= is_store && !misaligned5;
            o_rd_en           <= is_load && !misaligned5;
            o_byte_en         <= byte_en5;
            // result stage only sees legal loads
            o_load_op         <= (is_load && !misaligned5) ? mem_op_q5 : MEM_NONE;
            o_addr_misaligned <= misaligned5;
        end
    end

    // stage 6 payload
    always_ff @(posedge clk) begin
        o_addr  <= addr5;
        o_wdata <= op_b_q5;
    end

    assign o_byte_off = o_addr[1:0];

    // strobes are exclusive
    assert property (@(posedge clk) disable iff (!nrst) !(o_wr_en && o_rd_en));

    // lanes only open during a write
    assert property (@(posedge clk) disable iff (!nrst) !o_wr_en |-> (o_byte_en == '0));

endmodule

`default_nettype wire

// File: source/mem_stage.sv
//##############################
// fixed latency of two rising edges
// no handshake, one op taken per cycle
//##############################
`timescale 1ns/1ns
`default_nettype none
`include "mem_stage_defines.svh"

module mem_stage
    import mem_stage_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire mem_op_e          i_mem_op,
    input  wire logic [`XLEN-1:0] i_op_a,
    input  wire logic [`XLEN-1:0] i_op_b,
    input  wire logic [`XLEN-1:0] i_s_imm,
    output logic [`XLEN-1:0]      o_mem_out,
    output logic                  o_addr_misaligned
);
    // decode to memory
    logic             wr_en;
    logic             rd_en;
    byte_en_t         byte_en;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;

    // decode and memory to result
    mem_op_e          load_op;
    logic [1:0]       byte_off;
    word_bytes_t      rdata;

    mem_access_decode i_mem_access_decode (
        .clk               (clk),
        .nrst              (nrst),
        .i_mem_op          (i_mem_op),
        .i_op_a            (i_op_a),
        .i_op_b            (i_op_b),
        .i_s_imm           (i_s_imm),
        .o_wr_en           (wr_en),
        .o_rd_en           (rd_en),
        .o_byte_en         (byte_en),
        .o_addr            (addr),
        .o_wdata           (wdata),
        .o_load_op         (load_op),
        .o_byte_off        (byte_off),
        .o_addr_misaligned (o_addr_misaligned)
    );

    // write lands at the edge after stage 6
    data_mem i_data_mem (
        .clk       (clk),
        .nrst      (nrst),
        .i_wr_en   (wr_en),
        .i_rd_en   (rd_en),
        .i_byte_en (byte_en),
        .i_addr    (addr),
        .i_wdata   (wdata),
        .o_rdata   (rdata)
    );

    load_align i_load_align (
        .i_load_op  (load_op),
        .i_byte_off (byte_off),
        .i_rdata    (rdata),
        .o_mem_out  (o_mem_out)
    );

endmodule

`default_nettype wire

// File: source/mem_stage_defines.svh
//##############################
// sizes for the memory stage. DMEM_AW must equal log2(DMEM_WORDS)
// byte addresses above the array are not decoded
//##############################
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// data and address width
`define XLEN 32

// data memory depth in 32-bit words
`define DMEM_WORDS 256

// word address width
`define DMEM_AW 8

`endif

// File: source/mem_stage_pkg.sv
//##############################
// shared types of the memory stage
// store codes carry bit 3 set
//##############################
`default_nettype none

package mem_stage_pkg;

    // memory operation codes as issued by the execute stage
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        // stores
        MEM_SW   = 4'd8,
        MEM_SB   = 4'd14,
        MEM_SH   = 4'd15
    } mem_op_e;

    // one write enable per byte lane
    // lane 0 is the least significant byte
    typedef logic [3:0] byte_en_t;

    // data word seen as four byte lanes
    typedef logic [3:0][7:0] word_bytes_t;

endpackage

`default_nettype wire

// File: verif/mem_stage_golden.txt
// columns: group op op_a op_b s_imm expected_mem_out expected_misaligned, all hex
// groups: 1 reset, 2 word store/load, 3 lane merge, 4 extend, 5 misaligned, 6 operand split
1 3 00000000 00000000 00000000 00000000 0
1 3 00000100 00000010 00000000 00000000 0
1 1 00000000 000003ff 00000000 00000000 0
1 5 00000200 00000002 00000000 00000000 0
2 8 00000040 deadbeef 00000000 00000000 0
2 3 00000040 00000000 00000000 deadbeef 0
2 8 00000080 12345678 00000004 00000000 0
2 0 00000000 00000000 00000000 00000000 0
2 3 00000080 00000004 00000000 12345678 0
3 e 00000100 000000a5 00000000 00000000 0
3 e 00000100 005a0000 00000002 00000000 0
3 3 00000100 00000000 00000000 005a00a5 0
3 f 00000100 c3d40000 00000002 00000000 0
3 3 00000104 fffffffc 00000000 c3d400a5 0
3 e 00000100 0000ee00 00000001 00000000 0
3 3 00000100 00000000 00000000 c3d4eea5 0
4 8 00000200 7f8001fe 00000000 00000000 0
4 8 00000200 8001807f 00000004 00000000 0
4 1 00000200 00000000 00000000 fffffffe 0
4 1 00000200 00000001 00000000 00000001 0
4 1 00000200 00000002 00000000 ffffff80 0
4 1 00000200 00000003 00000000 0000007f 0
4 1 00000204 00000001 00000000 ffffff80 0
4 1 00000204 00000003 00000000 ffffff80 0
4 4 00000200 00000000 00000000 000000fe 0
4 4 00000204 00000001 00000000 00000080 0
4 4 00000200 00000002 00000000 00000080 0
4 4 00000200 00000003 00000000 0000007f 0
4 2 00000200 00000000 00000000 000001fe 0
4 2 00000200 00000002 00000000 00007f80 0
4 2 00000204 00000000 00000000 ffff807f 0
4 2 00000204 00000002 00000000 ffff8001 0
4 5 00000204 00000000 00000000 0000807f 0
4 5 00000204 00000002 00000000 00008001 0
5 8 00000300 11223344 00000000 00000000 0
5 2 00000300 00000001 00000000 00000000 1
5 5 00000300 00000003 00000000 00000000 1
5 3 00000300 00000002 00000000 00000000 1
5 f 00000300 0000aaaa 00000001 00000000 1
5 8 00000300 bbbbbbbb 00000003 00000000 1
5 3 00000300 00000000 00000000 11223344 0
6 0 00000000 00000000 00000000 00000000 0
6 0 ffffffff ffffffff ffffffff 00000000 0
6 8 00000300 5555aaaa 00000080 00000000 0
6 3 00000380 00000000 00000080 5555aaaa 0
6 3 00000300 00000080 00000000 5555aaaa 0
6 8 00000380 00000004 00000000 00000000 0
6 3 00000380 00000004 00000000 00000000 0
6 3 00000380 00000000 00000004 00000004 0

// File: verif/mem_stage_tb.sv
//##############################
// vectors come from verif/mem_stage_golden.txt, run from the project root
// one vector per cycle, results checked two rising edges later
//##############################
`timescale 1ns/1ns
`default_nettype none
`include "mem_stage_defines.svh"

module mem_stage_tb
    import mem_stage_pkg::*;
();
    localparam int MAX_VEC = 64;

    logic             clk;
    logic             nrst;
    mem_op_e          mem_op;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] mem_out;
    logic             addr_misaligned;

    // vector table
    logic [2:0]       grp_v     [MAX_VEC];
    logic [3:0]       op_v      [MAX_VEC];
    logic [`XLEN-1:0] a_v       [MAX_VEC];
    logic [`XLEN-1:0] b_v       [MAX_VEC];
    logic [`XLEN-1:0] s_v       [MAX_VEC];
    logic [`XLEN-1:0] exp_out_v [MAX_VEC];
    logic             exp_mis_v [MAX_VEC];

    int   nvec;
    int   errors;
    int   checks;
    logic loaded;

    mem_stage i_mem_stage (
        .clk               (clk),
        .nrst              (nrst),
        .i_mem_op          (mem_op),
        .i_op_a            (op_a),
        .i_op_b            (op_b),
        .i_s_imm           (s_imm),
        .o_mem_out         (mem_out),
        .o_addr_misaligned (addr_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic string group_name(input logic [2:0] g);
        case (g)
            3'd1:    return "reset_load";
            3'd2:    return "word_store_load";
            3'd3:    return "lane_merge";
            3'd4:    return "load_extend";
            3'd5:    return "misaligned";
            3'd6:    return "operand_split";
            default: return "unknown";
        endcase
    endfunction

    // load codes are 1 to 5
    function automatic logic is_load_code(input logic [3:0] op);
        return (op >= 4'd1) && (op <= 4'd5);
    endfunction

    // comment and blank lines do not scan as seven fields
    task automatic read_golden();
        int               fd;
        int               rc;
        string            line;
        logic [`XLEN-1:0] t_g, t_op, t_a, t_b, t_s, t_e, t_m;
        nvec = 0;
        fd = $fopen("verif/mem_stage_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && nvec < MAX_VEC) begin
                line = "";
                rc = $fgets(line, fd);
                rc = $sscanf(line, "%h %h %h %h %h %h %h", t_g, t_op, t_a, t_b, t_s, t_e, t_m);
                if (rc == 7) begin
                    grp_v[nvec]     = t_g[2:0];
                    op_v[nvec]      = t_op[3:0];
                    a_v[nvec]       = t_a;
                    b_v[nvec]       = t_b;
                    s_v[nvec]       = t_s;
                    exp_out_v[nvec] = t_e;
                    exp_mis_v[nvec] = t_m[0];
                    nvec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_vector(input int i);
        mem_op = mem_op_e'(op_v[i]);
        op_a   = a_v[i];
        op_b   = b_v[i];
        s_imm  = s_v[i];
    endtask

    task automatic check_vector(input int i, input string name,
                                input logic [`XLEN-1:0] exp_out);
        checks += 2;
        assert (mem_out === exp_out) else begin
            errors++;
            $display("ERROR %s vector %0d mem_out expected %08h actual %08h",
                     name, i, exp_out, mem_out);
        end
        assert (addr_misaligned === exp_mis_v[i]) else begin
            errors++;
            $display("ERROR %s vector %0d misaligned expected %0b actual %0b",
                     name, i, exp_mis_v[i], addr_misaligned);
        end
    endtask

    initial begin
        nrst   = 1'b0;
        mem_op = MEM_NONE;
        op_a   = '0;
        op_b   = '0;
        s_imm  = '0;
        errors = 0;
        checks = 0;
        loaded = 1'b0;
        read_golden();
        if (nvec == 0) begin
            $display("golden file could not be read or holds no vectors");
            $display("Regression failed");
            $finish;
        end else begin
            loaded = 1'b1;
            // two rising edges in reset
            repeat (2) @(posedge clk);
            @(negedge clk);
            nrst = 1'b1;
            // pass 1 replays only the loads after a second reset
            for (int pass = 0; pass < 2; pass++) begin
                if (pass == 1) begin
                    // reset clears every word, so each load reads zero
                    nrst = 1'b0;
                    repeat (2) @(posedge clk);
                    @(negedge clk);
                    nrst = 1'b1;
                end
                // check the vector from two cycles back, then drive the next
                for (int cyc = 0; cyc < nvec + 2; cyc++) begin
                    @(negedge clk);
                    if (cyc >= 2 && pass == 0) begin
                        check_vector(cyc - 2, group_name(grp_v[cyc - 2]), exp_out_v[cyc - 2]);
                    end else if (cyc >= 2 && is_load_code(op_v[cyc - 2])) begin
                        check_vector(cyc - 2, "reset_clear", '0);
                    end
                    if (cyc < nvec && (pass == 0 || is_load_code(op_v[cyc]))) begin
                        drive_vector(cyc);
                    end else begin
                        mem_op = MEM_NONE;
                    end
                end
            end
            $display("vectors %0d checks %0d errors %0d", nvec, checks, errors);
            if (errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

    // two passes over the vectors plus resets and drain, with margin
    initial begin
        wait (loaded);
        #((2 * nvec + 20) * 20);
        $display("watchdog expired, the run hung before all vectors were checked");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
